// File: branch_settings.svh
// Branch resolution settings
// Widths, return stack depth and fetch reset PC
`ifndef BRANCH_SETTINGS_SVH
`define BRANCH_SETTINGS_SVH

// Data and address width, RV32 only
`define BR_XLEN 32

// Instruction ID width
`define BR_ID_W 4

// Signed branch and jump offset width
`define BR_OFFSET_W 21

// Return stack entries, power of two
`define BR_RAS_DEPTH 4

// Fetch PC out of reset
`define BR_RESET_PC 32'h0000_0100

`endif

// File: branch_pkg.sv
// Branch resolution types
// Issue operands, instruction ID and exception packet
`include "branch_settings.svh"

package branch_pkg;

    // Instruction ID
    typedef logic [`BR_ID_W-1:0] id_t;

    // Operands and decode flags from issue
    typedef struct packed {
        logic [`BR_XLEN-1:0] rs1;
        logic [`BR_XLEN-1:0] rs2;
        logic signed [`BR_OFFSET_W-1:0] pc_offset;
        logic [`BR_XLEN-1:0] issue_pc;
        logic [2:0] fn3;
        logic use_signed;
        logic jal;
        logic jalr;
        logic is_call;
        logic is_return;
    } branch_inputs_t;

    // Exception causes, RISC-V mcause encoding
    typedef enum logic [4:0] {
        inst_addr_misaligned = 5'd0,
        inst_access_fault = 5'd1,
        illegal_inst = 5'd2,
        breakpoint = 5'd3
    } exception_code_t;

    // Exception packet towards the trap logic
    typedef struct packed {
        logic valid;
        exception_code_t code;
        logic [`BR_XLEN-1:0] pc;
        logic [`BR_XLEN-1:0] tval;
        id_t id;
    } br_exception_t;

endpackage

// File: ras_if.sv
// Return address stack interface
// Push side from the branch unit, pop side from fetch
`timescale 1ns/1ns
`include "branch_settings.svh"

interface ras_if;

    // Single-cycle strobes
    logic push;
    logic pop;
    logic [`BR_XLEN-1:0] push_addr;

    // Current top of stack
    logic [`BR_XLEN-1:0] top_addr;
    logic top_valid;

    modport pusher (output push, output push_addr);
    modport popper (output pop, input top_addr, input top_valid);
    modport stack (input push, input pop, input push_addr, output top_addr, output top_valid);

endinterface

// File: branch_result_if.sv
// Resolved branch results
// Carries completion, flush and target from the branch unit to fetch
`timescale 1ns/1ns
`include "branch_settings.svh"

interface branch_result_if;

    // Pulse when the held branch completes
    logic resolved;
    // Next PC mismatch, redirect fetch
    logic flush;
    logic [`BR_XLEN-1:0] new_pc;
    logic taken;
    // Misaligned target trap this cycle
    logic exc_valid;

    modport source (output resolved, output flush, output new_pc, output taken, output exc_valid);
    modport sink (input resolved, input flush, input new_pc, input taken, input exc_valid);

endinterface

// File: branch_unit.sv
// Branch unit
// Resolves conditional branches and jumps, holds the result until the
// next PC reaches issue, then flags a flush or a misaligned target
`timescale 1ns/1ns
`include "branch_settings.svh"

module branch_unit (
    input logic clk,
    input logic rst,

    input logic issue_valid,
    input branch_pkg::id_t issue_id,
    input branch_pkg::branch_inputs_t branch_in,

    input logic [`BR_XLEN-1:0] next_pc,
    input logic next_pc_valid,

    output logic branch_complete,
    output branch_pkg::id_t branch_id,
    output branch_pkg::br_exception_t exc,

    ras_if.pusher ras,
    branch_result_if.source res
);

    localparam int XLEN = `BR_XLEN;
    localparam int OFF_W = `BR_OFFSET_W;

    // Issue stage compare and target
    logic [XLEN:0] cmp_a;
    logic [XLEN:0] cmp_b;
    logic [XLEN:0] cmp_diff;
    logic cmp_lt;
    logic cmp_eq;
    logic cmp_result;
    logic taken;
    logic [XLEN-1:0] offset_ext;
    logic [XLEN-1:0] jump_base;
    logic [XLEN-1:0] target;

    // Held branch state
    logic held;
    logic completing;
    logic load_ex;
    logic ex_taken;
    logic [XLEN-1:0] ex_target;
    logic [XLEN-1:0] ex_pc;
    branch_pkg::id_t ex_id;

    //////////////////////////////
    // Comparator
    //////////////////////////////

    // Extend by one bit, sign or zero, so the difference MSB is the less-than
    assign cmp_a = {branch_in.use_signed & branch_in.rs1[XLEN-1], branch_in.rs1};
    assign cmp_b = {branch_in.use_signed & branch_in.rs2[XLEN-1], branch_in.rs2};
    assign cmp_diff = cmp_a - cmp_b;
    assign cmp_lt = cmp_diff[XLEN];
    assign cmp_eq = (branch_in.rs1 == branch_in.rs2);

    // fn3[2] picks less-than, fn3[0] inverts (bne, bge, bgeu)
    assign cmp_result = (branch_in.fn3[2] ? cmp_lt : cmp_eq) ^ branch_in.fn3[0];

    // Jumps always taken
    assign taken = cmp_result | branch_in.jal | branch_in.jalr;

    //////////////////////////////
    // Target adder
    //////////////////////////////

    assign offset_ext = {{(XLEN-OFF_W){branch_in.pc_offset[OFF_W-1]}}, branch_in.pc_offset};
    assign jump_base = branch_in.jalr ? branch_in.rs1 : branch_in.issue_pc;
    // Not taken falls through to pc + 4
    assign target = jump_base + (taken ? offset_ext : XLEN'(4));

    //////////////////////////////
    // Hold until next PC
    //////////////////////////////

    // Next instruction PC at issue completes the held branch
    assign completing = held & next_pc_valid;
    assign branch_complete = completing | exc.valid;

    // Idle or completing, so the ex stage is free
    assign load_ex = ~held | branch_complete;

    // New issue wins over completion
    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else if (issue_valid) begin
            held <= 1'b1;
        end else if (branch_complete) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_ex) begin
            ex_taken <= taken;
            ex_target[XLEN-1:1] <= target[XLEN-1:1];
            // JALR drops bit 0
            ex_target[0] <= target[0] & ~branch_in.jalr;
            ex_pc <= branch_in.issue_pc;
            ex_id <= issue_id;
        end
    end

    assign branch_id = ex_id;

    //////////////////////////////
    // Misaligned target
    //////////////////////////////

    // Only taken targets trap, first held cycle
    assign exc.valid = held & ex_taken & ex_target[1];
    assign exc.code = branch_pkg::inst_addr_misaligned;
    assign exc.pc = ex_pc;
    assign exc.tval = ex_target;
    assign exc.id = ex_id;

    //////////////////////////////
    // Results to fetch
    //////////////////////////////

    assign res.resolved = completing;
    // Bit 0 ignored in the compare, trapping branch never flushes
    assign res.flush = completing & ~exc.valid & (next_pc[XLEN-1:1] != ex_target[XLEN-1:1]);
    assign res.new_pc = ex_target;
    assign res.taken = ex_taken;
    assign res.exc_valid = exc.valid;

    //////////////////////////////
    // Return stack push
    //////////////////////////////

    // Call pushes its link address one cycle after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            ras.push <= 1'b0;
        end else begin
            ras.push <= issue_valid & branch_in.is_call;
        end
    end

    always_ff @(posedge clk) begin
        ras.push_addr <= branch_in.issue_pc + XLEN'(4);
    end

endmodule

// File: return_stack.sv
// Return address stack
// Circular buffer, oldest entry overwritten when full
`timescale 1ns/1ns
`include "branch_settings.svh"

module return_stack (
    input logic clk,
    input logic rst,
    ras_if.stack ras
);

    localparam int XLEN = `BR_XLEN;
    localparam int DEPTH = `BR_RAS_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [XLEN-1:0] entries [DEPTH];
    logic [PTR_W-1:0] top_ptr;
    logic [CNT_W-1:0] count;

    // After the pop, before the push
    logic do_pop;
    logic [PTR_W-1:0] ptr_mid;
    logic [CNT_W-1:0] count_mid;

    // Pop on an empty stack does nothing
    assign do_pop = ras.pop & (count != '0);
    assign ptr_mid = do_pop ? top_ptr - 1'b1 : top_ptr;
    assign count_mid = do_pop ? count - 1'b1 : count;

    always_ff @(posedge clk) begin
        if (rst) begin
            top_ptr <= '0;
            count <= '0;
        end else if (ras.push) begin
            top_ptr <= ptr_mid + 1'b1;
            // Saturate at depth
            count <= (count_mid == CNT_W'(DEPTH)) ? count_mid : count_mid + 1'b1;
        end else begin
            top_ptr <= ptr_mid;
            count <= count_mid;
        end
    end

    // Push lands one above the post-pop top
    always_ff @(posedge clk) begin
        if (ras.push) begin
            entries[ptr_mid + 1'b1] <= ras.push_addr;
        end
    end

    assign ras.top_addr = entries[top_ptr];
    assign ras.top_valid = (count != '0);

endmodule

// File: fetch_redirect.sv
// Fetch redirect
// Next fetch PC from a flush, a return prediction or a sequential step
`timescale 1ns/1ns
`include "branch_settings.svh"

module fetch_redirect (
    input logic clk,
    input logic rst,
    input logic fetch_advance,
    input logic fetch_is_return,

    branch_result_if.sink res,
    ras_if.popper ras,

    output logic [`BR_XLEN-1:0] fetch_pc,
    output logic fetch_from_ras
);

    localparam int XLEN = `BR_XLEN;

    logic redirect;
    logic predict;

    // Resolved mispredict, a trapping taken branch goes to the trap path
    assign redirect = res.resolved & res.flush & ~(res.exc_valid & res.taken);

    // Predecoded return with a valid stack top
    assign predict = ~redirect & fetch_advance & fetch_is_return & ras.top_valid;

    assign ras.pop = predict;
    assign fetch_from_ras = predict;

    //////////////////////////////
    // Fetch PC register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= `BR_RESET_PC;
        end else if (redirect) begin
            fetch_pc <= res.new_pc;
        end else if (predict) begin
            fetch_pc <= ras.top_addr;
        end else if (fetch_advance) begin
            fetch_pc <= fetch_pc + XLEN'(4);
        end
    end

endmodule

// File: branch_top.sv
// Branch resolution top level
// Branch unit, return stack and fetch redirect behind plain ports
`timescale 1ns/1ns
`include "branch_settings.svh"

module branch_top (
    input logic clk,
    input logic rst,

    // Issue
    input logic issue_valid,
    input logic [`BR_ID_W-1:0] issue_id,
    input logic [`BR_XLEN-1:0] rs1,
    input logic [`BR_XLEN-1:0] rs2,
    input logic [`BR_OFFSET_W-1:0] pc_offset,
    input logic [`BR_XLEN-1:0] issue_pc,
    input logic [2:0] fn3,
    input logic use_signed,
    input logic jal,
    input logic jalr,
    input logic is_call,
    input logic is_return,

    // Following instruction at issue
    input logic [`BR_XLEN-1:0] next_pc,
    input logic next_pc_valid,

    // Fetch
    input logic fetch_advance,
    input logic fetch_is_return,

    output logic branch_complete,
    output logic [`BR_ID_W-1:0] branch_id,
    output logic branch_flush,
    output logic [`BR_XLEN-1:0] branch_new_pc,
    output logic exc_valid,
    output logic [`BR_XLEN-1:0] exc_pc,
    output logic [`BR_XLEN-1:0] exc_tval,
    output logic [`BR_XLEN-1:0] fetch_pc,
    output logic fetch_from_ras
);

    branch_pkg::branch_inputs_t branch_in;
    branch_pkg::br_exception_t exc;

    ras_if ras_i ();
    branch_result_if res_i ();

    // Pack the issue operands
    assign branch_in.rs1 = rs1;
    assign branch_in.rs2 = rs2;
    assign branch_in.pc_offset = pc_offset;
    assign branch_in.issue_pc = issue_pc;
    assign branch_in.fn3 = fn3;
    assign branch_in.use_signed = use_signed;
    assign branch_in.jal = jal;
    assign branch_in.jalr = jalr;
    assign branch_in.is_call = is_call;
    assign branch_in.is_return = is_return;

    branch_unit branch_unit_i (
        .clk(clk),
        .rst(rst),
        .issue_valid(issue_valid),
        .issue_id(issue_id),
        .branch_in(branch_in),
        .next_pc(next_pc),
        .next_pc_valid(next_pc_valid),
        .branch_complete(branch_complete),
        .branch_id(branch_id),
        .exc(exc),
        .ras(ras_i.pusher),
        .res(res_i.source)
    );

    return_stack return_stack_i (
        .clk(clk),
        .rst(rst),
        .ras(ras_i.stack)
    );

    fetch_redirect fetch_redirect_i (
        .clk(clk),
        .rst(rst),
        .fetch_advance(fetch_advance),
        .fetch_is_return(fetch_is_return),
        .res(res_i.sink),
        .ras(ras_i.popper),
        .fetch_pc(fetch_pc),
        .fetch_from_ras(fetch_from_ras)
    );

    // Resolution and exception outputs
    assign branch_flush = res_i.flush;
    assign branch_new_pc = res_i.new_pc;
    assign exc_valid = exc.valid;
    assign exc_pc = exc.pc;
    assign exc_tval = exc.tval;

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset
// 8 ns clock, reset held over the first four rising edges
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: branch_tb.sv
// Branch resolution testbench
// Random branches, jumps, calls and returns against a reference model
`timescale 1ns/1ns
`include "branch_settings.svh"

module branch_tb;

    localparam int N_COND = 36;
    localparam int N_JUMP = 12;
    localparam int N_EXC = 4;
    localparam int N_CALL = `BR_RAS_DEPTH + 2;
    localparam int MAX_GAP = 4;
    // Four times the sum of all cases at their longest gap
    localparam int TIMEOUT_CYCLES = 4 * (N_COND + N_JUMP + N_EXC + 2 * N_CALL + 8) * (MAX_GAP + 3);

    logic clk;
    logic rst;
    logic issue_valid;
    logic [`BR_ID_W-1:0] issue_id;
    logic [`BR_XLEN-1:0] rs1;
    logic [`BR_XLEN-1:0] rs2;
    logic [`BR_OFFSET_W-1:0] pc_offset;
    logic [`BR_XLEN-1:0] issue_pc;
    logic [2:0] fn3;
    logic use_signed;
    logic jal;
    logic jalr;
    logic is_call;
    logic is_return;
    logic [`BR_XLEN-1:0] next_pc;
    logic next_pc_valid;
    logic fetch_advance;
    logic fetch_is_return;
    logic branch_complete;
    logic [`BR_ID_W-1:0] branch_id;
    logic branch_flush;
    logic [`BR_XLEN-1:0] branch_new_pc;
    logic exc_valid;
    logic [`BR_XLEN-1:0] exc_pc;
    logic [`BR_XLEN-1:0] exc_tval;
    logic [`BR_XLEN-1:0] fetch_pc;
    logic fetch_from_ras;

    // Reference model state
    logic m_held;
    logic m_taken;
    logic [`BR_XLEN-1:0] m_target;
    logic [`BR_XLEN-1:0] m_pc;
    logic [`BR_ID_W-1:0] m_id;
    logic m_push;
    logic [`BR_XLEN-1:0] m_push_addr;
    logic [`BR_XLEN-1:0] m_fetch_pc;
    logic [`BR_XLEN-1:0] ras_model [$];

    // Expected outputs set on the falling edge
    logic exp_complete;
    logic [`BR_ID_W-1:0] exp_id;
    logic exp_flush;
    logic [`BR_XLEN-1:0] exp_new_pc;
    logic exp_exc;
    logic [`BR_XLEN-1:0] exp_exc_pc;
    logic [`BR_XLEN-1:0] exp_exc_tval;
    logic [`BR_XLEN-1:0] exp_fetch_pc;
    logic exp_from_ras;

    integer seed;
    int fail_count;
    int test_count;
    int cycle_count = 0;
    logic [`BR_ID_W-1:0] next_id;
    logic [2:0] fn_codes [6];

    tb_clock_gen clock_gen_i (.clk(clk), .rst(rst));

    branch_top dut_i (.*);

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        fail_count++;
        $display("Fail at %0t: %s is %h, expected %h", $time, name, got, expected);
    endtask

    complete_check: assert property (@(posedge clk) disable iff (rst)
        branch_complete == exp_complete)
        else report_mismatch("branch_complete", 32'($sampled(branch_complete)),
                             32'($sampled(exp_complete)));
    id_check: assert property (@(posedge clk) disable iff (rst)
        branch_complete |-> branch_id == exp_id)
        else report_mismatch("branch_id", 32'($sampled(branch_id)), 32'($sampled(exp_id)));
    flush_check: assert property (@(posedge clk) disable iff (rst)
        branch_flush == exp_flush)
        else report_mismatch("branch_flush", 32'($sampled(branch_flush)),
                             32'($sampled(exp_flush)));
    new_pc_check: assert property (@(posedge clk) disable iff (rst)
        branch_complete |-> branch_new_pc == exp_new_pc)
        else report_mismatch("branch_new_pc", $sampled(branch_new_pc), $sampled(exp_new_pc));
    exc_check: assert property (@(posedge clk) disable iff (rst)
        exc_valid == exp_exc)
        else report_mismatch("exc_valid", 32'($sampled(exc_valid)), 32'($sampled(exp_exc)));
    exc_pc_check: assert property (@(posedge clk) disable iff (rst)
        exc_valid |-> exc_pc == exp_exc_pc)
        else report_mismatch("exc_pc", $sampled(exc_pc), $sampled(exp_exc_pc));
    exc_tval_check: assert property (@(posedge clk) disable iff (rst)
        exc_valid |-> exc_tval == exp_exc_tval)
        else report_mismatch("exc_tval", $sampled(exc_tval), $sampled(exp_exc_tval));
    fetch_pc_check: assert property (@(posedge clk) disable iff (rst)
        fetch_pc == exp_fetch_pc)
        else report_mismatch("fetch_pc", $sampled(fetch_pc), $sampled(exp_fetch_pc));
    from_ras_check: assert property (@(posedge clk) disable iff (rst)
        fetch_from_ras == exp_from_ras)
        else report_mismatch("fetch_from_ras", 32'($sampled(fetch_from_ras)),
                             32'($sampled(exp_from_ras)));

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // Taken flag and target from RV32 branch and jump rules
    function automatic logic [`BR_XLEN:0] resolve_branch();
        logic [`BR_XLEN-1:0] off;
        logic less;
        logic cond;
        off = {{(`BR_XLEN - `BR_OFFSET_W){pc_offset[`BR_OFFSET_W-1]}}, pc_offset};
        less = use_signed ? ($signed(rs1) < $signed(rs2)) : (rs1 < rs2);
        case (fn3)
            3'd0: cond = (rs1 == rs2);
            3'd1: cond = (rs1 != rs2);
            3'd4, 3'd6: cond = less;
            3'd5, 3'd7: cond = ~less;
            default: cond = 1'b0;
        endcase
        if (jalr) begin
            return {1'b1, (rs1 + off) & ~32'd1};
        end else if (cond | jal) begin
            return {1'b1, issue_pc + off};
        end
        return {1'b0, issue_pc + 32'd4};
    endfunction

    // One clock cycle with inputs already driven
    task automatic step(output logic done);
        logic [`BR_XLEN:0] res;
        exp_exc = m_held & m_taken & m_target[1];
        exp_complete = (m_held & next_pc_valid) | exp_exc;
        exp_flush = m_held & next_pc_valid & ~exp_exc & (next_pc[31:1] != m_target[31:1]);
        exp_new_pc = m_target;
        exp_id = m_id;
        exp_exc_pc = m_pc;
        exp_exc_tval = m_target;
        exp_from_ras = ~exp_flush & fetch_advance & fetch_is_return & (ras_model.size() != 0);
        exp_fetch_pc = m_fetch_pc;
        #1;
        done = branch_complete;
        @(posedge clk);
        // Fetch first and then the stack so pop comes before push
        if (exp_flush) begin
            m_fetch_pc = m_target;
        end else if (exp_from_ras) begin
            m_fetch_pc = ras_model.pop_back();
        end else if (fetch_advance) begin
            m_fetch_pc = m_fetch_pc + 32'd4;
        end
        if (m_push) begin
            ras_model.push_back(m_push_addr);
            if (ras_model.size() > `BR_RAS_DEPTH) begin
                void'(ras_model.pop_front());
            end
        end
        m_push = issue_valid & is_call;
        m_push_addr = issue_pc + 32'd4;
        if (issue_valid) begin
            res = resolve_branch();
            m_held = 1'b1;
            m_taken = res[`BR_XLEN];
            m_target = res[`BR_XLEN-1:0];
            m_pc = issue_pc;
            m_id = issue_id;
        end else if (exp_complete) begin
            m_held = 1'b0;
        end
        @(negedge clk);
    endtask

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    task automatic load_cond_branch(input logic [2:0] fn);
        logic [31:0] r;
        r = rand_word();
        rs1 = rand_word();
        // Equal operands half the time
        rs2 = r[0] ? rs1 : rand_word();
        issue_pc = {r[31:2], 2'b00};
        r = rand_word();
        pc_offset = {r[20:2], 2'b00};
        fn3 = fn;
        use_signed = ~fn[1];
        jal = 1'b0;
        jalr = 1'b0;
        is_call = 1'b0;
    endtask

    task automatic load_jump(input logic use_jalr);
        logic [31:0] r;
        r = rand_word();
        rs1 = {r[31:2], 2'b00};
        rs2 = rand_word();
        issue_pc = {rand_word() & ~32'd3};
        r = rand_word();
        // JALR gets an odd offset at times so bit 0 must drop
        pc_offset = use_jalr ? {r[20:2], 1'b0, r[0]} : {r[20:2], 2'b00};
        fn3 = 3'd0;
        use_signed = 1'b0;
        jal = ~use_jalr;
        jalr = use_jalr;
        is_call = 1'b0;
    endtask

    task automatic start_issue();
        issue_valid = 1'b1;
        issue_id = next_id;
        next_id = next_id + 1'b1;
    endtask

    task automatic clear_issue();
        issue_valid = 1'b0;
        jal = 1'b0;
        jalr = 1'b0;
        is_call = 1'b0;
    endtask

    task automatic issue_branch();
        logic done;
        start_issue();
        step(done);
        clear_issue();
    endtask

    // Next PC arrives after a gap and then wait for completion
    task automatic finish_branch(input logic [31:0] npc, input int gap);
        logic done;
        logic [31:0] r;
        int waited;
        done = 1'b0;
        waited = 0;
        next_pc = npc;
        while (!done) begin
            r = rand_word();
            fetch_advance = r[0];
            next_pc_valid = (waited >= gap);
            step(done);
            waited++;
        end
        next_pc_valid = 1'b0;
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_count++;
        $display("Test %0d %s finished, %0d failed checks", test_count, name,
                 fail_count - errs_before);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic reset_state_test();
        logic done;
        int errs;
        errs = fail_count;
        repeat (3) step(done);
        end_test("reset state", errs);
    endtask

    task automatic cond_branch_test();
        logic [`BR_XLEN:0] res;
        logic [31:0] pc;
        logic [31:0] r;
        int errs;
        errs = fail_count;
        for (int i = 0; i < N_COND; i++) begin
            load_cond_branch(fn_codes[i % 6]);
            res = resolve_branch();
            pc = issue_pc;
            issue_branch();
            r = rand_word();
            finish_branch(r[0] ? res[31:0] : pc + 32'd4, int'(r[3:1]) % (MAX_GAP + 1));
        end
        end_test("conditional branches", errs);
    endtask

    // Each jump issues in the completion cycle of the one before
    task automatic jump_test();
        logic done;
        logic [31:0] r;
        int errs;
        errs = fail_count;
        load_jump(1'b0);
        issue_branch();
        for (int i = 1; i < N_JUMP; i++) begin
            r = rand_word();
            fetch_advance = r[3];
            repeat (int'(r[2:1])) step(done);
            next_pc = r[0] ? m_target : m_pc + 32'd4;
            next_pc_valid = 1'b1;
            load_jump(i[0]);
            start_issue();
            step(done);
            clear_issue();
            next_pc_valid = 1'b0;
        end
        finish_branch(m_target, 1);
        end_test("jal and jalr", errs);
    endtask

    task automatic misaligned_test();
        int errs;
        errs = fail_count;
        for (int i = 0; i < N_EXC; i++) begin
            if (i[0]) begin
                load_jump(1'b0);
            end else begin
                load_cond_branch(3'd0);
                rs2 = rs1;
            end
            // Bit 1 set on an aligned PC makes the taken target misaligned
            pc_offset[1] = 1'b1;
            issue_branch();
            // Mismatching next PC in the trap cycle must not flush
            finish_branch(m_pc + 32'd4, 0);
        end
        end_test("misaligned target", errs);
    endtask

    task automatic return_stack_test();
        logic done;
        int errs;
        errs = fail_count;
        for (int i = 0; i < N_CALL; i++) begin
            load_jump(1'b0);
            is_call = 1'b1;
            issue_branch();
            finish_branch(m_target, 0);
        end
        // Newest entries in LIFO order and then the empty fallback
        fetch_advance = 1'b1;
        fetch_is_return = 1'b1;
        repeat (N_CALL) step(done);
        fetch_advance = 1'b0;
        fetch_is_return = 1'b0;
        step(done);
        end_test("return stack", errs);
    endtask

    task automatic fetch_priority_test();
        logic done;
        int errs;
        errs = fail_count;
        load_jump(1'b0);
        is_call = 1'b1;
        issue_branch();
        finish_branch(m_target, 0);
        load_jump(1'b0);
        pc_offset = 21'h000100;
        issue_branch();
        fetch_advance = 1'b0;
        step(done);
        // Mispredict and return prediction in one cycle
        next_pc = m_pc + 32'd4;
        next_pc_valid = 1'b1;
        fetch_advance = 1'b1;
        fetch_is_return = 1'b1;
        step(done);
        next_pc_valid = 1'b0;
        fetch_advance = 1'b0;
        fetch_is_return = 1'b0;
        // Stalled fetch holds
        repeat (3) step(done);
        fetch_advance = 1'b1;
        fetch_is_return = 1'b1;
        step(done);
        fetch_advance = 1'b0;
        fetch_is_return = 1'b0;
        step(done);
        end_test("fetch priority", errs);
    endtask

    //////////////////////////////
    // Main and timeout
    //////////////////////////////

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, a branch never completed", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        seed = 32'h24c;
        fail_count = 0;
        test_count = 0;
        next_id = '0;
        fn_codes = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        issue_valid = 1'b0;
        issue_id = '0;
        rs1 = '0;
        rs2 = '0;
        pc_offset = '0;
        issue_pc = '0;
        fn3 = 3'd0;
        use_signed = 1'b0;
        jal = 1'b0;
        jalr = 1'b0;
        is_call = 1'b0;
        is_return = 1'b0;
        next_pc = '0;
        next_pc_valid = 1'b0;
        fetch_advance = 1'b0;
        fetch_is_return = 1'b0;
        m_held = 1'b0;
        m_taken = 1'b0;
        m_target = '0;
        m_pc = '0;
        m_id = '0;
        m_push = 1'b0;
        m_push_addr = '0;
        m_fetch_pc = `BR_RESET_PC;
        exp_complete = 1'b0;
        exp_id = '0;
        exp_flush = 1'b0;
        exp_new_pc = '0;
        exp_exc = 1'b0;
        exp_exc_pc = '0;
        exp_exc_tval = '0;
        exp_fetch_pc = `BR_RESET_PC;
        exp_from_ras = 1'b0;
        wait (!rst);
        @(negedge clk);
        reset_state_test();
        cond_branch_test();
        jump_test();
        misaligned_test();
        return_stack_test();
        fetch_priority_test();
        $display("Summary: %0d tests run, %0d failed checks", test_count, fail_count);
        if (fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
branch_pkg.sv
ras_if.sv
branch_result_if.sv
branch_unit.sv
return_stack.sv
fetch_redirect.sv
branch_top.sv
tb_clock_gen.sv
branch_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= branch_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= No errors
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ns -j 0

SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL: see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
